// File: list.f
logic/tile_cfg_pkg.sv
logic/tile_fabric_pkg.sv
logic/cfg_bus_if.sv
logic/cfg_decoder.sv
logic/connect_box.sv
logic/logic_block.sv
logic/switch_box.sv
logic/pe_tile.sv
tests/pe_tile_props.sv
tests/pe_tile_tb.sv

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module pe_tile_tb -f list.f -o pe_tile_sim \
   && ./obj_dir/pe_tile_sim | tee sim.log \
   && grep -qF "*** TEST PASSED ***" sim.log \
   && echo "simulation run ok" \
   || { echo "simulation run reported a problem"; exit 1; }

// File: tests/pe_tile_tb.sv
`timescale 1ns/1ns

module pe_tile_tb;
   import tile_cfg_pkg::*;
   import tile_fabric_pkg::*;

   localparam tile_id_t my_id = 16'h0123;

   logic      clk;
   logic      arst_n;
   cfg_addr_t config_addr;
   cfg_word_t config_data;
   tile_id_t  tile_id;
   tracks_t   tracks_in;
   tracks_t   tracks_out;

   // stimulus table where each entry owns wr_count[e] consecutive writes.
   logic [15:0] wr_code  [$];
   cfg_word_t   wr_data  [$];
   bit          wr_match [$];
   int          wr_count [$];
   tracks_t     tin_tab  [$];
   string       name_tab [$];
   int          pending = 0;

   // the shadow of the tile configuration follows the writes as they are applied.
   logic [cb_sel_w-1:0] sh_cb0;
   logic [cb_sel_w-1:0] sh_cb1;
   logic_op_e           sh_op;
   sb_src_e             sh_sb [num_wires];

   int cycles = 0;
   int limit  = 1000;
   int errors = 0;

   pe_tile uut (
      .clk         (clk),
      .arst_n      (arst_n),
      .config_addr (config_addr),
      .config_data (config_data),
      .tile_id     (tile_id),
      .tracks_in   (tracks_in),
      .tracks_out  (tracks_out)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= limit) begin
         $display("timeout: the run did not finish within %0d clock cycles", limit);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   task automatic add_write(input logic [15:0] code, input cfg_word_t data, input bit match);
      wr_code.push_back(code);
      wr_data.push_back(data);
      wr_match.push_back(match);
      pending++;
   endtask

   task automatic add_entry(input string name, input tracks_t tin);
      name_tab.push_back(name);
      tin_tab.push_back(tin);
      wr_count.push_back(pending);
      pending = 0;
   endtask

   // sixteen fields cycling through next, opposite and prev.
   function automatic cfg_word_t mix_word(input int shift);
      cfg_word_t w;
      w = '0;
      for (int i = 0; i < num_wires; i++) begin
         w[i*sb_sel_w +: sb_sel_w] = 2'((i + shift) % 3);
      end
      return w;
   endfunction

   task automatic build_table();
      tracks_t tin;
      add_entry("reset defaults", 16'h9e37);
      add_write(tgt_sb, mix_word(0), 1'b1);
      add_entry("mixed routing", 16'hc5a1);
      add_write(tgt_sb, mix_word(2), 1'b1);
      add_entry("mixed routing shifted", 16'h3b6d);
      for (int op = 0; op < 8; op++) begin
         for (int j = 0; j < 4; j++) begin
            if (j == 0) begin
               if (op == 0) begin
                  add_write(tgt_sb, 32'hffff_ffff, 1'b1);   // every output from the logic block.
               end
               add_write(tgt_cb0, 32'(op % 4), 1'b1);
               add_write(tgt_cb1, 32'((op + 2) % 4), 1'b1);
               add_write(tgt_clb, 32'(op), 1'b1);
            end
            tin = tracks_t'($urandom);
            tin[op % 4] = j[0];
            tin[num_tracks + (op + 2) % 4] = j[1];
            add_entry($sformatf("opcode %0d case %0d", op, j), tin);
         end
      end
      add_write(tgt_sb, 32'h0, 1'b0);
      add_write(16'd0, 32'h0, 1'b1);
      add_write(16'd9, 32'h0, 1'b1);
      add_write(tgt_clb, 32'd6, 1'b0);
      add_entry("ignored writes", 16'h5d2c);
      for (int r = 0; r < 8; r++) begin
         add_write(tgt_sb, cfg_word_t'($urandom), 1'b1);
         add_write(tgt_cb0, cfg_word_t'($urandom), 1'b1);
         add_write(tgt_cb1, cfg_word_t'($urandom), 1'b1);
         add_write(tgt_clb, cfg_word_t'($urandom), 1'b1);
         add_entry($sformatf("random %0d", r), tracks_t'($urandom));
      end
   endtask

   // only a matching id with a mapped target code reaches a register.
   task automatic note_write(input logic [15:0] code, input cfg_word_t data, input bit match);
      if (match) begin
         case (code)
            tgt_cb0: sh_cb0 = data[cb_sel_w-1:0];
            tgt_cb1: sh_cb1 = data[cb_sel_w-1:0];
            tgt_clb: sh_op = logic_op_e'(data[op_w-1:0]);
            tgt_sb: begin
               for (int i = 0; i < num_wires; i++) begin
                  sh_sb[i] = sb_src_e'(data[i*sb_sel_w +: sb_sel_w]);
               end
            end
            default: ;
         endcase
      end
   endtask

   function automatic tracks_t expected_tracks(input tracks_t tin);
      tracks_t want;
      logic    a;
      logic    b;
      logic    y;
      int      src_side;
      a = tin[sh_cb0];
      b = tin[num_tracks + sh_cb1];
      case (sh_op)
         op_and, op_nand: y = a & b;
         op_or, op_nor:   y = a | b;
         op_xor, op_xnor: y = a ^ b;
         default:         y = a;
      endcase
      if (sh_op inside {op_nand, op_nor, op_xnor, op_not_a}) begin
         y = ~y;   // nand, nor, xnor and not_a complement their base operation.
      end
      for (int s = 0; s < num_sides; s++) begin
         for (int t = 0; t < num_tracks; t++) begin
            if (sh_sb[s*num_tracks + t] == src_clb) begin
               want[s*num_tracks + t] = y;
            end else begin
               src_side = (s + 1 + int'(sh_sb[s*num_tracks + t])) % num_sides;
               want[s*num_tracks + t] = tin[src_side*num_tracks + t];
            end
         end
      end
      return want;
   endfunction

   task automatic check_tracks(input tracks_t want, input tracks_t got, output bit ok);
      ok = (got === want);
      if (!ok) begin
         $display("[FAIL] %0t ns tracks_out expected 16'h%04h got 16'h%04h", $time, want, got);
         errors++;
      end
   endtask

   initial begin
      int  wi;
      int  failed;
      bit  ok;
      logic [15:0] code;
      wi = 0;
      failed = 0;
      void'($urandom(20));
      arst_n = 1'b1;
      tile_id = my_id;
      config_addr = {16'd0, ~my_id};   // idle address never matches.
      config_data = '0;
      tracks_in = 16'ha5c3;
      sh_cb0 = '0;
      sh_cb1 = '0;
      sh_op = op_and;
      for (int i = 0; i < num_wires; i++) begin
         sh_sb[i] = src_next;
      end
      build_table();
      limit = tin_tab.size() * 12 + 50;
      #1 arst_n = 1'b0;
      repeat (9) @(posedge clk);
      #1;
      check_tracks('0, tracks_out, ok);
      if (ok) begin
         $display("[PASS] reset: tracks_out held at zero");
      end else begin
         failed++;
      end
      @(posedge clk);
      #1 arst_n = 1'b1;
      for (int e = 0; e < tin_tab.size(); e++) begin
         for (int k = 0; k < wr_count[e]; k++) begin
            @(posedge clk);
            #1;
            code = wr_code[wi];
            config_addr = {code, wr_match[wi] ? my_id : ~my_id};
            config_data = wr_data[wi];
            note_write(code, wr_data[wi], wr_match[wi]);
            wi++;
         end
         repeat (2) begin
            @(posedge clk);
            #1;
            config_addr = {16'd0, ~my_id};
            config_data = cfg_word_t'($urandom);
         end
         @(posedge clk);
         #1 tracks_in = tin_tab[e];
         repeat (4) @(posedge clk);   // long enough for the logic path too.
         #1;
         check_tracks(expected_tracks(tin_tab[e]), tracks_out, ok);
         if (ok) begin
            $display("[PASS] test %0d %s", e, name_tab[e]);
         end else begin
            $display("test %0d %s finished with a mismatch", e, name_tab[e]);
            failed++;
         end
      end
      $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
               tin_tab.size() + 1, tin_tab.size() + 1 - failed, failed, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// File: tests/pe_tile_props.sv
`timescale 1ns/1ns

module pe_tile_props (
   input logic                     clk,
   input logic                     arst_n,
   input tile_fabric_pkg::tracks_t tracks_out,
   input logic                     wr_cb0,
   input logic                     wr_cb1,
   input logic                     wr_sb,
   input logic                     wr_clb
);

   // the asynchronous clear holds every output track low for the whole reset.
   property outputs_clear_in_reset;
      @(posedge clk) !arst_n |-> (tracks_out == '0);
   endproperty

   property one_strobe_at_most;
      @(posedge clk) disable iff (!arst_n) $onehot0({wr_cb0, wr_cb1, wr_sb, wr_clb});
   endproperty

   property outputs_known;
      @(posedge clk) disable iff (!arst_n) !$isunknown(tracks_out);
   endproperty

   reset_clear_a: assert property (outputs_clear_in_reset)
      else $error("tracks_out is not zero while reset is asserted");

   strobe_excl_a: assert property (one_strobe_at_most)
      else $error("more than one configuration strobe is high");   // decoder fault.

   known_out_a: assert property (outputs_known)
      else $error("tracks_out holds unknown bits after reset");

endmodule

bind pe_tile pe_tile_props props (
   .clk        (clk),
   .arst_n     (arst_n),
   .tracks_out (tracks_out),
   .wr_cb0     (cfg.wr_cb0),
   .wr_cb1     (cfg.wr_cb1),
   .wr_sb      (cfg.wr_sb),
   .wr_clb     (cfg.wr_clb)
);

// File: logic/pe_tile.sv
`timescale 1ns/1ns

module pe_tile (
   input  logic                     clk,
   input  logic                     arst_n,
   input  tile_cfg_pkg::cfg_addr_t  config_addr,
   input  tile_cfg_pkg::cfg_word_t  config_data,
   input  tile_cfg_pkg::tile_id_t   tile_id,
   input  tile_fabric_pkg::tracks_t tracks_in,
   output tile_fabric_pkg::tracks_t tracks_out
);
   import tile_cfg_pkg::*;
   import tile_fabric_pkg::*;

   logic operand0;
   logic operand1;
   logic clb_result;

   cfg_bus_if cfg ();

   cfg_decoder u_dec (
      .clk         (clk),
      .arst_n      (arst_n),
      .config_addr (config_addr),
      .config_data (config_data),
      .tile_id     (tile_id),
      .cfg         (cfg.source)
   );

   // operand a comes from side 0, operand b from side 1.
   connect_box cb0 (
      .clk     (clk),
      .arst_n  (arst_n),
      .cfg     (cfg.sink),
      .which   (tgt_cb0),
      .side_in (tracks_in[0 +: num_tracks]),
      .operand (operand0)
   );

   connect_box cb1 (
      .clk     (clk),
      .arst_n  (arst_n),
      .cfg     (cfg.sink),
      .which   (tgt_cb1),
      .side_in (tracks_in[num_tracks +: num_tracks]),
      .operand (operand1)
   );

   logic_block clb (
      .clk      (clk),
      .arst_n   (arst_n),
      .cfg      (cfg.sink),
      .operand0 (operand0),
      .operand1 (operand1),
      .result   (clb_result)
   );

   switch_box sb (
      .clk        (clk),
      .arst_n     (arst_n),
      .cfg        (cfg.sink),
      .tracks_in  (tracks_in),
      .clb_result (clb_result),
      .tracks_out (tracks_out)
   );

endmodule

// File: logic/switch_box.sv
`timescale 1ns/1ns

module switch_box (
   input  logic                    clk,
   input  logic                    arst_n,
   cfg_bus_if.sink                 cfg,
   input  tile_fabric_pkg::tracks_t tracks_in,
   input  logic                    clb_result,
   output tile_fabric_pkg::tracks_t tracks_out
);
   import tile_fabric_pkg::*;

   sb_src_e sel [num_wires];
   tracks_t nxt;

   // field for output wire i sits at bit i * sb_sel_w of the data word.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < num_wires; i++) begin
            sel[i] <= src_next;
         end
      end else if (cfg.wr_sb) begin
         for (int i = 0; i < num_wires; i++) begin
            sel[i] <= sb_src_e'(cfg.data[i*sb_sel_w +: sb_sel_w]);
         end
      end
   end

   // an output only ever takes the same track number from another side.
   always_comb begin
      nxt = '0;
      for (int s = 0; s < num_sides; s++) begin
         for (int t = 0; t < num_tracks; t++) begin
            case (sel[s*num_tracks + t])
               src_next: begin
                  nxt[s*num_tracks + t] = tracks_in[((s + 1) % num_sides)*num_tracks + t];
               end
               src_opposite: begin
                  nxt[s*num_tracks + t] = tracks_in[((s + 2) % num_sides)*num_tracks + t];
               end
               src_prev: begin
                  nxt[s*num_tracks + t] = tracks_in[((s + 3) % num_sides)*num_tracks + t];
               end
               default: begin
                  nxt[s*num_tracks + t] = clb_result;
               end
            endcase
         end
      end
   end

   // stage 3 is the only driver of the tile outputs.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         tracks_out <= '0;
      end else begin
         tracks_out <= nxt;
      end
   end

endmodule

// File: logic/logic_block.sv
`timescale 1ns/1ns

module logic_block (
   input  logic    clk,
   input  logic    arst_n,
   cfg_bus_if.sink cfg,
   input  logic    operand0,
   input  logic    operand1,
   output logic    result
);
   import tile_cfg_pkg::*;
   import tile_fabric_pkg::*;

   logic_op_e op;
   logic      a;
   logic      b;
   logic      y;

   assign a = operand0;
   assign b = operand1;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         op <= op_and;
      end else if (cfg.wr_clb) begin
         op <= logic_op_e'(cfg.data[op_w-1:0]);
      end
   end

   always_comb begin
      case (op)
         op_and:    y = a & b;
         op_or:     y = a | b;
         op_xor:    y = a ^ b;
         op_nand:   y = ~(a & b);
         op_nor:    y = ~(a | b);
         op_xnor:   y = ~(a ^ b);
         op_pass_a: y = a;
         op_not_a:  y = ~a;
         default:   y = 1'b0;
      endcase
   end

   // stage 2 registers the result one cycle behind the connect boxes.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         result <= 1'b0;
      end else begin
         result <= y;
      end
   end

endmodule

// File: logic/connect_box.sv
`timescale 1ns/1ns

module connect_box (
   input  logic                         clk,
   input  logic                         arst_n,
   cfg_bus_if.sink                      cfg,
   input  tile_cfg_pkg::cfg_target_e    which,
   input  tile_fabric_pkg::side_tracks_t side_in,
   output logic                         operand
);
   import tile_cfg_pkg::*;

   logic                wr;
   logic [cb_sel_w-1:0] sel;

   // each instance listens to the strobe of its own target.
   always_comb begin
      case (which)
         tgt_cb0: wr = cfg.wr_cb0;
         tgt_cb1: wr = cfg.wr_cb1;
         default: wr = 1'b0;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sel <= '0;
      end else if (wr) begin
         sel <= cfg.data[cb_sel_w-1:0];
      end
   end

   // stage 1 of the data path.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         operand <= 1'b0;
      end else begin
         operand <= side_in[sel];
      end
   end

endmodule

// File: logic/cfg_decoder.sv
`timescale 1ns/1ns

module cfg_decoder (
   input  logic                    clk,
   input  logic                    arst_n,
   input  tile_cfg_pkg::cfg_addr_t config_addr,
   input  tile_cfg_pkg::cfg_word_t config_data,
   input  tile_cfg_pkg::tile_id_t  tile_id,
   cfg_bus_if.source               cfg
);
   import tile_cfg_pkg::*;

   logic        hit;
   cfg_target_e target;

   assign hit    = (config_addr[id_w-1:0] == tile_id);
   assign target = cfg_target_e'(config_addr[addr_w-1:id_w]);

   // codes outside the map fall through every compare and raise nothing.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cfg.wr_cb0 <= 1'b0;
         cfg.wr_cb1 <= 1'b0;
         cfg.wr_sb  <= 1'b0;
         cfg.wr_clb <= 1'b0;
      end else begin
         cfg.wr_cb0 <= hit && (target == tgt_cb0);
         cfg.wr_cb1 <= hit && (target == tgt_cb1);
         cfg.wr_sb  <= hit && (target == tgt_sb);
         cfg.wr_clb <= hit && (target == tgt_clb);
      end
   end

   always_ff @(posedge clk) begin
      cfg.data <= config_data;   // lines up with the strobes.
   end

endmodule

// File: logic/cfg_bus_if.sv
`timescale 1ns/1ns

interface cfg_bus_if;
   import tile_cfg_pkg::*;

   // the write strobes last one cycle and at most one is high at a time.
   logic      wr_cb0;
   logic      wr_cb1;
   logic      wr_sb;
   logic      wr_clb;
   cfg_word_t data;

   modport source (
      output wr_cb0,
      output wr_cb1,
      output wr_sb,
      output wr_clb,
      output data
   );

   modport sink (
      input wr_cb0,
      input wr_cb1,
      input wr_sb,
      input wr_clb,
      input data
   );

endinterface

// File: logic/tile_fabric_pkg.sv
package tile_fabric_pkg;

   localparam int num_sides  = 4;
   localparam int num_tracks = 4;
   localparam int num_wires  = num_sides * num_tracks;

   // each output track has its own switch box select field of this width.
   localparam int sb_sel_w = 2;

   // bit index is side * num_tracks + track.
   typedef logic [num_wires-1:0]  tracks_t;
   typedef logic [num_tracks-1:0] side_tracks_t;

   typedef enum logic [2:0] {
      op_and,
      op_or,
      op_xor,
      op_nand,
      op_nor,
      op_xnor,
      op_pass_a,
      op_not_a
   } logic_op_e;

   // sources are counted from the output side, modulo num_sides.
   typedef enum logic [sb_sel_w-1:0] {
      src_next,       // side s+1.
      src_opposite,   // side s+2.
      src_prev,       // side s+3.
      src_clb
   } sb_src_e;

endpackage

// File: logic/tile_cfg_pkg.sv
package tile_cfg_pkg;

   // a configuration address carries the tile id in its low half
   // and the target code in its high half.
   localparam int id_w   = 16;
   localparam int addr_w = 2 * id_w;
   localparam int data_w = 32;

   // field widths inside the configuration data word.
   localparam int cb_sel_w = 2;   // track select sits in the low bits.
   localparam int op_w     = 3;   // opcode sits in the low bits.

   typedef logic [id_w-1:0]   tile_id_t;
   typedef logic [addr_w-1:0] cfg_addr_t;
   typedef logic [data_w-1:0] cfg_word_t;

   // target codes found in the high address half.
   typedef enum logic [id_w-1:0] {
      tgt_cb0 = 16'd4,
      tgt_cb1 = 16'd5,
      tgt_sb  = 16'd6,
      tgt_clb = 16'd7
   } cfg_target_e;

endpackage
